//--- list.f
verilog/daq_pkg.sv
verilog/ram_readout.sv
verilog/word_fifo.sv
verilog/event_framer.sv
verilog/readout_ctrl.sv
verilog/daq_readout_top.sv
tests/tb_asic_model.sv
tests/tb_daq_readout.sv

//--- tests/tb_daq_readout.sv
`timescale 1ns/1ps

module tb_daq_readout;

  import daq_pkg::*;

  localparam int FIFO_DEPTH   = 8;
  localparam int LINK_CREDITS = 4;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int N_EVENTS     = 4;
  // Clocks of header, drain and trailer slack per event
  localparam int EVENT_MARGIN = 200;

  // Event table
  // Event 2 stalls the link so more than FIFO_DEPTH words arrive
  localparam logic [7:0] EV_CHIP [N_EVENTS] = '{8'h3A, 8'h51, 8'hC7, 8'h0E};
  localparam int EV_WORDS [N_EVENTS] = '{4, 3, FIFO_DEPTH + LINK_CREDITS + 2, 2};
  localparam int EV_EXTRA [N_EVENTS] = '{0, 5, 0, 0};
  localparam bit EV_HOLD [N_EVENTS] = '{1'b0, 1'b0, 1'b1, 1'b0};

  logic       Clk;
  logic       reset_n;
  logic       dout;
  logic       transmit_n;
  logic       start;
  logic [7:0] chip_id;
  logic       link_credit;
  logic       link_valid;
  link_word_t link_word;
  logic       busy;

  // Expected stream
  logic [15:0] exp_q [$];
  logic [15:0] exp_head;
  logic        exp_avail;
  logic [7:0]  exp_chip;
  logic [7:0]  exp_seq;
  logic        exp_ovf;
  logic        exp_partial;

  // Link side tracking
  logic        in_event;
  logic [7:0]  data_seen;
  int          rel_count;
  logic        hold;
  int          sent_total;
  int          returned_total;
  int          events_done;
  int          words_checked;
  int          errors;
  logic [15:0] lfsr;

  logic is_header;
  logic is_data;
  logic is_trailer;

  initial Clk = 1'b0;
  always #(CLK_PERIOD / 2) Clk = ~Clk;

  daq_readout_top #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .LINK_CREDITS (LINK_CREDITS)
  ) u_dut (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .dout        (dout),
    .transmit_n  (transmit_n),
    .start       (start),
    .chip_id     (chip_id),
    .link_credit (link_credit),
    .link_valid  (link_valid),
    .link_word   (link_word),
    .busy        (busy)
  );

  tb_asic_model u_asic (
    .Clk        (Clk),
    .dout       (dout),
    .transmit_n (transmit_n)
  );

  assign is_header  = link_valid && link_word.kind == KIND_HEADER;
  assign is_data    = link_valid && link_word.kind == KIND_DATA;
  assign is_trailer = link_valid && link_word.kind == KIND_TRAILER;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Taps x^16 x^14 x^13 x^11 shifting right
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  // One step per bit taken with LSB first
  function automatic logic [15:0] random_bits(input int nbits);
    logic [15:0] w;
    int          b;
    w = '0;
    for (b = 0; b < nbits; b++) begin
      w[b] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return w;
  endfunction

  // Mirror of the queue front for the assertions
  function automatic void refresh_head();
    exp_avail = (exp_q.size() != 0);
    if (exp_avail) begin
      exp_head = exp_q[0];
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("[FAIL] %0t ns %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  task automatic print_summary();
    $display("Events %0d of %0d, link words %0d, ASIC bits %0d, errors %0d",
             events_done, N_EVENTS, words_checked, u_asic.bits_sent, errors);
  endtask

  //////////////////////////////
  // Consumer side
  //////////////////////////////

  // Each received word owes one credit back unless holding
  always @(negedge Clk) begin
    link_credit = reset_n && !hold && (returned_total < sent_total);
  end

  always @(posedge Clk) begin
    if (reset_n) begin
      if (link_valid) begin
        sent_total <= sent_total + 1;
      end
      if (link_credit) begin
        returned_total <= returned_total + 1;
      end
    end
  end

  // Event framing as seen on the link
  always @(posedge Clk) begin
    if (reset_n && link_valid) begin
      words_checked <= words_checked + 1;
      case (link_word.kind)
        KIND_HEADER: begin
          in_event  <= 1'b1;
          data_seen <= '0;
          rel_count <= 0;
        end
        KIND_DATA: begin
          data_seen <= data_seen + 1'b1;
          // Words that waited out the stall
          if (!hold) begin
            rel_count <= rel_count + 1;
          end
          if (exp_q.size() != 0) begin
            void'(exp_q.pop_front());
          end
          refresh_head();
        end
        KIND_TRAILER: begin
          in_event    <= 1'b0;
          exp_seq     <= exp_seq + 1'b1;
          events_done <= events_done + 1;
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////
  // Link checks
  //////////////////////////////

  a_reset_quiet: assert property (
    @(posedge Clk) (!reset_n || $rose(reset_n)) |-> !link_valid
  ) else report_mismatch("link_valid", 0, $sampled(link_valid));

  a_credit_limit: assert property (
    @(posedge Clk) disable iff (!reset_n)
    link_valid |-> sent_total < LINK_CREDITS + returned_total
  ) else report_problem("word sent beyond the credits granted");

  a_header_order: assert property (
    @(posedge Clk) disable iff (!reset_n) is_header |-> !in_event
  ) else report_problem("header inside an open event");

  a_body_order: assert property (
    @(posedge Clk) disable iff (!reset_n) (is_data || is_trailer) |-> in_event
  ) else report_problem("data or trailer word outside an event");

  a_header_chip: assert property (
    @(posedge Clk) disable iff (!reset_n) is_header |-> link_word.body.info.tag == exp_chip
  ) else report_mismatch("header chip id", $sampled(exp_chip),
                         $sampled(link_word.body.info.tag));

  a_header_seq: assert property (
    @(posedge Clk) disable iff (!reset_n) is_header |-> link_word.body.info.count == exp_seq
  ) else report_mismatch("header sequence", $sampled(exp_seq),
                         $sampled(link_word.body.info.count));

  a_data_expected: assert property (
    @(posedge Clk) disable iff (!reset_n) is_data |-> exp_avail
  ) else report_problem("data word sent with none expected");

  a_data_value: assert property (
    @(posedge Clk) disable iff (!reset_n)
    is_data && exp_avail |-> link_word.body.raw == exp_head
  ) else report_mismatch("link_word.body.raw", $sampled(exp_head),
                         $sampled(link_word.body.raw));

  a_trailer_count: assert property (
    @(posedge Clk) disable iff (!reset_n)
    is_trailer |-> link_word.body.info.count == data_seen
  ) else report_mismatch("trailer count", $sampled(data_seen),
                         $sampled(link_word.body.info.count));

  a_trailer_overflow: assert property (
    @(posedge Clk) disable iff (!reset_n)
    is_trailer |-> link_word.body.info.tag[STATUS_OVERFLOW] == exp_ovf
  ) else report_mismatch("trailer overflow bit", $sampled(exp_ovf),
                         $sampled(link_word.body.info.tag[STATUS_OVERFLOW]));

  a_trailer_partial: assert property (
    @(posedge Clk) disable iff (!reset_n)
    is_trailer |-> link_word.body.info.tag[STATUS_PARTIAL] == exp_partial
  ) else report_mismatch("trailer partial bit", $sampled(exp_partial),
                         $sampled(link_word.body.info.tag[STATUS_PARTIAL]));

  a_trailer_drained: assert property (
    @(posedge Clk) disable iff (!reset_n) is_trailer |-> !exp_avail
  ) else report_problem("trailer sent before all expected data words");

  // A full FIFO comes out after the stall
  a_overflow_drain: assert property (
    @(posedge Clk) disable iff (!reset_n) is_trailer && exp_ovf |-> rel_count == FIFO_DEPTH
  ) else report_mismatch("words after stall", FIFO_DEPTH, $sampled(rel_count));

  a_busy_release: assert property (
    @(posedge Clk) disable iff (!reset_n) is_trailer |=> !busy
  ) else report_mismatch("busy", 0, $sampled(busy));

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Runs one event from start to trailer
  task automatic run_event(input int ev);
    logic [15:0] w;
    int          keep;
    int          i;
    // Stalled event keeps the spare credits plus a full FIFO
    keep = EV_HOLD[ev] ? (LINK_CREDITS - 1 + FIFO_DEPTH) : EV_WORDS[ev];
    while (busy || returned_total != sent_total) @(negedge Clk);
    exp_chip    = EV_CHIP[ev];
    exp_ovf     = EV_HOLD[ev];
    exp_partial = (EV_EXTRA[ev] != 0);
    hold        = EV_HOLD[ev];
    start       = 1'b1;
    chip_id     = EV_CHIP[ev];
    @(negedge Clk);
    start = 1'b0;
    for (i = 0; i < EV_WORDS[ev]; i++) begin
      w = random_bits(BITS_PER_WORD);
      if (i < keep) begin
        exp_q.push_back(w);
        refresh_head();
      end
      u_asic.send_word(w);
    end
    // Tail bits that never make a word
    if (EV_EXTRA[ev] != 0) begin
      w = random_bits(EV_EXTRA[ev]);
      u_asic.send_bits(w, EV_EXTRA[ev]);
    end
    u_asic.end_frame();
    hold = 1'b0;
    // Stray start while the event still drains
    start   = 1'b1;
    chip_id = ~EV_CHIP[ev];
    @(negedge Clk);
    start = 1'b0;
    while (busy) @(negedge Clk);
  endtask

  initial begin : stimulus
    int ev;
    reset_n        = 1'b0;
    start          = 1'b0;
    chip_id        = '0;
    link_credit    = 1'b0;
    hold           = 1'b0;
    exp_head       = '0;
    exp_avail      = 1'b0;
    exp_chip       = '0;
    exp_seq        = '0;
    exp_ovf        = 1'b0;
    exp_partial    = 1'b0;
    in_event       = 1'b0;
    data_seen      = '0;
    rel_count      = 0;
    sent_total     = 0;
    returned_total = 0;
    events_done    = 0;
    words_checked  = 0;
    errors         = 0;
    lfsr           = 16'd43068;
    repeat (RESET_CYCLES) @(negedge Clk);
    reset_n = 1'b1;
    for (ev = 0; ev < N_EVENTS; ev++) begin
      run_event(ev);
    end
    // Last credits home before closing
    while (returned_total != sent_total) @(negedge Clk);
    repeat (4) @(negedge Clk);
    if (events_done != N_EVENTS) begin
      report_problem($sformatf("only %0d of %0d events finished", events_done, N_EVENTS));
    end
    if (exp_q.size() != 0) begin
      report_problem($sformatf("%0d expected data words never arrived", exp_q.size()));
    end
    print_summary();
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Serial time of every event plus slack
  initial begin : watchdog
    int e;
    int clocks;
    clocks = RESET_CYCLES;
    for (e = 0; e < N_EVENTS; e++) begin
      clocks += (EV_WORDS[e] * BITS_PER_WORD + EV_EXTRA[e]) * CLKS_PER_BIT + EVENT_MARGIN;
    end
    #(clocks * CLK_PERIOD);
    report_problem("watchdog expired before all events finished");
    print_summary();
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- tests/tb_asic_model.sv
`timescale 1ns/1ps

module tb_asic_model (
  input  logic Clk,
  output logic dout,
  output logic transmit_n
);

  import daq_pkg::*;

  // Bits put on the pin so far
  int bits_sent;

  // Both pins idle high between frames
  initial begin
    dout       = 1'b1;
    transmit_n = 1'b1;
    bits_sent  = 0;
  end

  //////////////////////////////
  // Serializer tasks
  //////////////////////////////

  // Entered on a falling edge, returns on one
  // LSB first, pin level is the inverted bit
  task automatic send_bits(input logic [15:0] word, input int nbits);
    int b;
    for (b = 0; b < nbits; b++) begin
      transmit_n = 1'b0;
      dout       = !word[b];
      bits_sent++;
      // Hold for one bit period
      repeat (CLKS_PER_BIT) @(negedge Clk);
    end
  endtask

  // Full hit word
  task automatic send_word(input logic [15:0] word);
    send_bits(word, BITS_PER_WORD);
  endtask

  // Frame closes on the same falling edge
  task automatic end_frame();
    transmit_n = 1'b1;
    dout       = 1'b1;
  endtask

endmodule

//--- verilog/daq_readout_top.sv
`timescale 1ns/1ps

module daq_readout_top #(
  parameter int FIFO_DEPTH   = 8,
  parameter int LINK_CREDITS = 4
) (
  input  logic                Clk,
  input  logic                reset_n,
  input  logic                dout,
  input  logic                transmit_n,
  input  logic                start,
  input  logic [7:0]          chip_id,
  input  logic                link_credit,
  output logic                link_valid,
  output daq_pkg::link_word_t link_word,
  output logic                busy
);

  import daq_pkg::*;

  // Deserializer side
  logic        word_valid;
  logic [15:0] word_data;
  logic        xmit_active;
  logic        partial_end;

  // FIFO side
  logic [15:0] fifo_data;
  logic        fifo_empty;
  logic        fifo_pop;
  logic        overflow;
  logic        clear_overflow;

  // Control to framer
  framer_cmd_t framer_cmd;
  frame_info_t frame_info;
  logic        xfer_end;
  logic        cmd_done;
  logic [7:0]  sent_count;

  ram_readout u_ram_readout (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .dout        (dout),
    .transmit_n  (transmit_n),
    .word_valid  (word_valid),
    .xmit_active (xmit_active),
    .partial_end (partial_end),
    .word_data   (word_data)
  );

  word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_word_fifo (
    .Clk            (Clk),
    .reset_n        (reset_n),
    .push           (word_valid),
    .pop            (fifo_pop),
    .clear_overflow (clear_overflow),
    .push_data      (word_data),
    .fifo_data      (fifo_data),
    .fifo_empty     (fifo_empty),
    .overflow       (overflow)
  );

  event_framer #(
    .LINK_CREDITS (LINK_CREDITS)
  ) u_event_framer (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .link_credit (link_credit),
    .framer_cmd  (framer_cmd),
    .frame_info  (frame_info),
    .xfer_end    (xfer_end),
    .fifo_empty  (fifo_empty),
    .fifo_data   (fifo_data),
    .fifo_pop    (fifo_pop),
    .cmd_done    (cmd_done),
    .link_valid  (link_valid),
    .link_word   (link_word),
    .sent_count  (sent_count)
  );

  readout_ctrl u_readout_ctrl (
    .Clk            (Clk),
    .reset_n        (reset_n),
    .start          (start),
    .chip_id        (chip_id),
    .xmit_active    (xmit_active),
    .partial_end    (partial_end),
    .overflow       (overflow),
    .cmd_done       (cmd_done),
    .sent_count     (sent_count),
    .framer_cmd     (framer_cmd),
    .frame_info     (frame_info),
    .xfer_end       (xfer_end),
    .clear_overflow (clear_overflow),
    .busy           (busy)
  );

endmodule

//--- verilog/readout_ctrl.sv
`timescale 1ns/1ps

module readout_ctrl (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 start,
  input  logic [7:0]           chip_id,
  input  logic                 xmit_active,
  input  logic                 partial_end,
  input  logic                 overflow,
  input  logic                 cmd_done,
  input  logic [7:0]           sent_count,
  output daq_pkg::framer_cmd_t framer_cmd,
  output daq_pkg::frame_info_t frame_info,
  output logic                 xfer_end,
  output logic                 clear_overflow,
  output logic                 busy
);

  import daq_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_DATA,
    ST_TRAILER
  } state_t;

  state_t     state;
  logic [7:0] chip_q;
  logic [7:0] seq_num;
  logic       xmit_q;
  logic       partial_seen;
  logic       accept;

  assign busy   = (state != ST_IDLE);
  assign accept = (state == ST_IDLE) && start;

  //////////////////////////////
  // Event FSM
  //////////////////////////////

  // Each step waits for the framer
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:    if (start) state <= ST_HEADER;
        ST_HEADER:  if (cmd_done) state <= ST_DATA;
        ST_DATA:    if (cmd_done) state <= ST_TRAILER;
        ST_TRAILER: if (cmd_done) state <= ST_IDLE;
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // Chip latch and sequence number
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      chip_q  <= '0;
      seq_num <= '0;
    end else begin
      if (accept) begin
        chip_q <= chip_id;
      end
      // Next event gets the next number
      if (state == ST_TRAILER && cmd_done) begin
        seq_num <= seq_num + 1'b1;
      end
    end
  end

  // Transfer end and partial word tracking
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      xmit_q       <= 1'b0;
      partial_seen <= 1'b0;
      xfer_end     <= 1'b0;
    end else begin
      xmit_q <= xmit_active;
      if (accept) begin
        partial_seen <= 1'b0;
        xfer_end     <= 1'b0;
      end else if (busy) begin
        if (partial_end) begin
          partial_seen <= 1'b1;
        end
        // Falling edge of transmit
        if (xmit_q && !xmit_active) begin
          xfer_end <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Framer command and info
  //////////////////////////////

  always_comb begin
    case (state)
      ST_HEADER:  framer_cmd = CMD_HEADER;
      ST_DATA:    framer_cmd = CMD_DATA;
      ST_TRAILER: framer_cmd = CMD_TRAILER;
      default:    framer_cmd = CMD_NONE;
    endcase
  end

  always_comb begin
    frame_info = '0;
    if (state == ST_TRAILER) begin
      frame_info.tag[STATUS_OVERFLOW] = overflow;
      frame_info.tag[STATUS_PARTIAL]  = partial_seen;
      frame_info.count                = sent_count;
    end else begin
      frame_info.tag   = chip_q;
      frame_info.count = seq_num;
    end
  end

  // Overflow dropped once the trailer has reported it
  assign clear_overflow = (state == ST_TRAILER) && cmd_done;

  // Start during an event never reopens the header
  a_start_ignored: assert property (
    @(posedge Clk) disable iff (!reset_n)
    start && busy && state != ST_HEADER |=> state != ST_HEADER
  ) else $error("start while busy restarted the event");

  c_start_busy: cover property (
    @(posedge Clk) disable iff (!reset_n) start && busy
  ) $warning("start while busy ignored");

endmodule

//--- verilog/event_framer.sv
`timescale 1ns/1ps

module event_framer #(
  parameter int LINK_CREDITS = 4
) (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 link_credit,
  input  daq_pkg::framer_cmd_t framer_cmd,
  input  daq_pkg::frame_info_t frame_info,
  input  logic                 xfer_end,
  input  logic                 fifo_empty,
  input  logic [15:0]          fifo_data,
  output logic                 fifo_pop,
  output logic                 cmd_done,
  output logic                 link_valid,
  output daq_pkg::link_word_t  link_word,
  output logic [7:0]           sent_count
);

  import daq_pkg::*;

  localparam int CRED_W = $clog2(LINK_CREDITS + 1);

  logic [CRED_W-1:0] credits;
  logic              have_credit;

  assign have_credit = (credits != '0);

  //////////////////////////////
  // Word select and send
  //////////////////////////////

  always_comb begin
    link_valid         = 1'b0;
    fifo_pop           = 1'b0;
    cmd_done           = 1'b0;
    // Raw view by default
    link_word.kind     = KIND_DATA;
    link_word.body.raw = fifo_data;
    case (framer_cmd)
      CMD_HEADER: begin
        link_word.kind      = KIND_HEADER;
        link_word.body.info = frame_info;
        link_valid          = have_credit;
        cmd_done            = have_credit;
      end
      CMD_DATA: begin
        // Pop and send in one cycle
        link_valid = have_credit && !fifo_empty;
        fifo_pop   = have_credit && !fifo_empty;
        // Drained and ASIC finished
        cmd_done   = fifo_empty && xfer_end;
      end
      CMD_TRAILER: begin
        link_word.kind      = KIND_TRAILER;
        link_word.body.info = frame_info;
        link_valid          = have_credit;
        cmd_done            = have_credit;
      end
      default: begin
      end
    endcase
  end

  // Credit counter where a return and a spend together cancel
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      credits <= CRED_W'(LINK_CREDITS);
    end else if (link_credit && !link_valid) begin
      credits <= credits + 1'b1;
    end else if (link_valid && !link_credit) begin
      credits <= credits - 1'b1;
    end
  end

  // Data word count of the current event cleared by the header
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      sent_count <= '0;
    end else if (link_valid && framer_cmd == CMD_HEADER) begin
      sent_count <= '0;
    end else if (link_valid && framer_cmd == CMD_DATA) begin
      sent_count <= sent_count + 1'b1;
    end
  end

  // Spending the last credit stops the link until one comes back
  a_send_needs_credit: assert property (
    @(posedge Clk) disable iff (!reset_n)
    link_valid && !link_credit && credits == CRED_W'(1) |=> !link_valid
  ) else $error("link_valid with no credit");

  // Consumer never returns more than it was given
  a_credit_bound: assert property (
    @(posedge Clk) disable iff (!reset_n) credits <= CRED_W'(LINK_CREDITS)
  ) else $error("credit count above LINK_CREDITS");

endmodule

//--- verilog/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        push,
  input  logic        pop,
  input  logic        clear_overflow,
  input  logic [15:0] push_data,
  output logic [15:0] fifo_data,
  output logic        fifo_empty,
  output logic        overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [15:0]      mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full       = (count == CNT_W'(FIFO_DEPTH));
  assign fifo_empty = (count == '0);
  // Full push is lost, ASIC cannot wait
  assign do_push    = push && !full;
  assign do_pop     = pop && !fifo_empty;

  // Show-ahead read
  assign fifo_data = mem[rd_ptr];

  always_ff @(posedge Clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Sticky drop flag, new drop beats clear
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end else if (clear_overflow) begin
      overflow <= 1'b0;
    end
  end

  // Framer must check empty before popping
  a_no_pop_empty: assert property (
    @(posedge Clk) disable iff (!reset_n) pop |-> !fifo_empty
  ) else $error("pop while FIFO empty");

endmodule

//--- verilog/ram_readout.sv
`timescale 1ns/1ps

module ram_readout (
  input  logic        Clk,
  input  logic        reset_n,
  input  logic        dout,
  input  logic        transmit_n,
  output logic        word_valid,
  output logic        xmit_active,
  output logic        partial_end,
  output logic [15:0] word_data
);

  import daq_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(BITS_PER_WORD);

  logic             dout_q;
  logic             transmit_n_q;
  logic [CNT_W-1:0] slow_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             sample;
  logic             last_bit;
  logic [15:0]      word_buf;

  //////////////////////////////
  // Pin synchronizer
  //////////////////////////////

  // Both pins idle high
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      dout_q       <= 1'b1;
      transmit_n_q <= 1'b1;
    end else begin
      dout_q       <= dout;
      transmit_n_q <= transmit_n;
    end
  end

  assign xmit_active = !transmit_n_q;

  //////////////////////////////
  // Bit timing
  //////////////////////////////

  // Slow counter, restarts with each transmission
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      slow_cnt <= '0;
    end else if (!xmit_active) begin
      slow_cnt <= '0;
    end else if (slow_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      slow_cnt <= '0;
    end else begin
      slow_cnt <= slow_cnt + 1'b1;
    end
  end

  // Mid-period sample point
  assign sample   = xmit_active && (slow_cnt == CNT_W'(SAMPLE_PHASE));
  assign last_bit = (bit_idx == IDX_W'(BITS_PER_WORD - 1));

  // Bit index and word strobe
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      bit_idx    <= '0;
      word_valid <= 1'b0;
    end else begin
      // One cycle after the last bit lands
      word_valid <= sample && last_bit;
      if (!xmit_active) begin
        bit_idx <= '0;
      end else if (sample) begin
        bit_idx <= last_bit ? '0 : bit_idx + 1'b1;
      end
    end
  end

  // Assembly buffer, pin is active low
  always_ff @(posedge Clk) begin
    if (sample) begin
      word_buf[bit_idx] <= !dout_q;
    end
  end

  assign word_data = word_buf;

  // Index still nonzero in first idle cycle means a half-built word
  assign partial_end = !xmit_active && (bit_idx != '0);

  // Completed words are at least one bit period apart
  a_word_valid_pulse: assert property (
    @(posedge Clk) disable iff (!reset_n) word_valid |=> !word_valid
  ) else $error("word_valid high two cycles in a row");

endmodule

//--- verilog/daq_pkg.sv
package daq_pkg;

  //////////////////////////////
  // Serial timing
  //////////////////////////////

  // ASIC word width, LSB first on the pin
  localparam int BITS_PER_WORD = 16;
  // System clocks per serial bit
  localparam int CLKS_PER_BIT = 8;
  // Slow count where the bit is stable
  localparam int SAMPLE_PHASE = 3;

  // Trailer status bits
  localparam int STATUS_OVERFLOW = 0;
  localparam int STATUS_PARTIAL = 1;

  //////////////////////////////
  // Link word
  //////////////////////////////

  typedef enum logic [1:0] {
    KIND_HEADER  = 2'd0,
    KIND_DATA    = 2'd1,
    KIND_TRAILER = 2'd2
  } word_kind_t;

  // Header: chip id + sequence number
  // Trailer: status + data word count
  typedef struct packed {
    logic [7:0] tag;
    logic [7:0] count;
  } frame_info_t;

  // Same 16 bits, hit data or frame info
  typedef union packed {
    logic [15:0] raw;
    frame_info_t info;
  } link_body_u;

  typedef struct packed {
    word_kind_t kind;
    link_body_u body;
  } link_word_t;

  // Control to framer
  typedef enum logic [1:0] {
    CMD_NONE    = 2'd0,
    CMD_HEADER  = 2'd1,
    CMD_DATA    = 2'd2,
    CMD_TRAILER = 2'd3
  } framer_cmd_t;

endpackage
